//--- src/afu_cmd_pkg.sv
package afu_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // command and abort encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [12:0] {
    CMD_INVALID    = 13'h0000, // idle / after reset
    CMD_RESTART    = 13'h0001,
    CMD_READ_CL_S  = 13'h0A50, // wed fetch
    CMD_WRITE_NA   = 13'h0D00,
    CMD_READ_CL_NA = 13'h0A00
  } cmd_code_t;

  typedef enum logic [2:0] {
    STRICT = 3'd0,
    ABORT  = 3'd1, // only mode driven
    PAGE   = 3'd2,
    PERF   = 3'd3,
    SPEC   = 3'd4
  } abort_t;

  typedef enum logic [1:0] {
    KIND_RESTART = 2'd0,
    KIND_WED     = 2'd1,
    KIND_WRITE   = 2'd2,
    KIND_READ    = 2'd3
  } req_kind_t;

  localparam int TAG_W = 8;
  localparam logic [TAG_W-1:0] INVALID_TAG = 8'hFF; // never handed out
  localparam int MAX_CREDITS = 4;                  // outstanding limit

  // register map, byte offsets
  localparam logic [7:0] REG_CTRL    = 8'h00;
  localparam logic [7:0] REG_ADDR_LO = 8'h04;
  localparam logic [7:0] REG_ADDR_HI = 8'h08;
  localparam logic [7:0] REG_SIZE    = 8'h0C;
  localparam logic [7:0] REG_REQ     = 8'h10;
  localparam logic [7:0] REG_STATUS  = 8'h14; // read only

  // request fsm state encoding
  localparam logic [1:0] ST_IDLE        = 2'd0;
  localparam logic [1:0] ST_WAIT_CREDIT = 2'd1;
  localparam logic [1:0] ST_ISSUE       = 2'd2;

  // odd parity over a zero padded word
  function automatic logic odd_parity(input logic [63:0] data);
    return ~(^data); // data + parity has an odd count of ones
  endfunction

endpackage

//--- src/apb_cmd_regs.sv
`timescale 1ns/1ps

module apb_cmd_regs
  import afu_cmd_pkg::*;
(
  input  logic        clock,
  input  logic        rstn,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic        req_taken,   // pulse from fsm on issue
  input  logic [2:0]  outstanding,
  output logic [31:0] prdata,
  output logic        pslverr,
  output logic        enabled,
  output logic        req_pending,
  output req_kind_t   req_kind,
  output logic [63:0] req_address,
  output logic [11:0] req_size
);

  logic        access;
  logic        mapped;
  logic        wr_en;
  logic        req_write;
  logic [31:0] addr_lo;
  logic [31:0] addr_hi;
  logic [15:0] issued;

  //////////////////////////////////////////////////////////////////////
  // apb decode, zero wait states
  //////////////////////////////////////////////////////////////////////

  assign access    = psel & penable; // access phase only
  assign mapped    = paddr inside {REG_CTRL, REG_ADDR_LO, REG_ADDR_HI,
                                   REG_SIZE, REG_REQ, REG_STATUS};
  assign wr_en     = access & pwrite & mapped;
  assign req_write = wr_en & (paddr == REG_REQ);

  // unmapped, or a second request on top of a pending one
  assign pslverr = access & (~mapped | (req_write & req_pending));

  assign req_address = {addr_hi, addr_lo};

  // configuration registers
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled  <= 1'b0;
      addr_lo  <= '0;
      addr_hi  <= '0;
      req_size <= '0;
      req_kind <= KIND_RESTART;
    end else if (wr_en) begin
      case (paddr)
        REG_CTRL:    enabled  <= pwdata[0];
        REG_ADDR_LO: addr_lo  <= pwdata;
        REG_ADDR_HI: addr_hi  <= pwdata;
        REG_SIZE:    req_size <= pwdata[11:0];
        REG_REQ:     if (!req_pending) req_kind <= req_kind_t'(pwdata[1:0]); // busy write dropped
        default:     ; // status is read only
      endcase
    end
  end

  // single pending request, plus issued command count
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      req_pending <= 1'b0;
      issued      <= '0;
    end else begin
      if (req_taken) req_pending <= 1'b0;      // fsm took it
      else if (req_write) req_pending <= 1'b1;
      if (req_taken) issued <= issued + 16'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (paddr)
      REG_CTRL:    prdata = {31'b0, enabled};
      REG_ADDR_LO: prdata = addr_lo;
      REG_ADDR_HI: prdata = addr_hi;
      REG_SIZE:    prdata = {20'b0, req_size};
      REG_REQ:     prdata = {30'b0, req_kind};
      REG_STATUS:  prdata = {issued, 5'b0, outstanding, 7'b0, req_pending};
      default:     prdata = '0;
    endcase
  end

endmodule

//--- src/cmd_request_fsm.sv
`timescale 1ns/1ps

module cmd_request_fsm
  import afu_cmd_pkg::*;
(
  input  logic             clock,
  input  logic             rstn,
  input  logic             enabled,
  input  logic             req_pending,
  input  req_kind_t        req_kind,
  input  logic [63:0]      req_address,
  input  logic [11:0]      req_size,
  input  logic             credit_free,
  input  logic [TAG_W-1:0] next_tag,
  output logic             req_taken,
  output logic             alloc,
  output logic             line_valid,
  output cmd_code_t        line_command,
  output logic [63:0]      line_address,
  output logic [11:0]      line_size,
  output logic [TAG_W-1:0] line_tag
);

  logic [1:0] state;
  logic       go;   // request can issue at this edge
  logic       wait_credit;
  logic       is_restart;

  assign wait_credit = req_pending & enabled & ~credit_free;
  assign go          = req_pending & enabled & credit_free &
                       (state != ST_ISSUE);
  assign is_restart  = (req_kind == KIND_RESTART);

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:        if (go) state <= ST_ISSUE;
                        else if (wait_credit) state <= ST_WAIT_CREDIT;
        ST_WAIT_CREDIT: if (go) state <= ST_ISSUE; // enable low just holds
        default:        state <= ST_IDLE;          // issue lasts one cycle
      endcase
    end
  end

  // line payload, captured on the edge into issue
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      line_command <= CMD_INVALID; // idle code until the first issue
      line_address <= '0;
      line_size    <= '0;
      line_tag     <= INVALID_TAG;
    end else if (go) begin
      line_address <= is_restart ? 64'h0 : req_address; // restart has no target
      line_size    <= is_restart ? 12'h0 : req_size;
      line_tag     <= next_tag;
      case (req_kind)
        KIND_RESTART: line_command <= CMD_RESTART;
        KIND_WED:     line_command <= CMD_READ_CL_S;
        KIND_WRITE:   line_command <= CMD_WRITE_NA;
        default:      line_command <= CMD_READ_CL_NA;
      endcase
    end
  end

  // one line, one tag, one ack per issue
  assign line_valid = (state == ST_ISSUE);
  assign alloc      = line_valid;
  assign req_taken  = line_valid;

endmodule

//--- src/tag_credit_counter.sv
`timescale 1ns/1ps

module tag_credit_counter
  import afu_cmd_pkg::*;
(
  input  logic             clock,
  input  logic             rstn,
  input  logic             alloc,
  input  logic             response_valid,
  input  logic [TAG_W-1:0] response_tag,
  output logic [TAG_W-1:0] next_tag,
  output logic             credit_free,
  output logic [2:0]       outstanding
);

  logic release_credit;

  // a response with nothing outstanding, or with the invalid tag, is dropped
  assign release_credit = response_valid & (outstanding != 3'd0) &
                          (response_tag != INVALID_TAG);

  assign credit_free = (outstanding < 3'(MAX_CREDITS));

  //////////////////////////////////////////////////////////////////////
  // rolling tag, wraps before INVALID_TAG
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      next_tag <= '0;
    end else if (alloc) begin
      next_tag <= (next_tag == INVALID_TAG - 8'd1) ? '0 : next_tag + 8'd1; // mod 255
    end
  end

  // outstanding count, alloc and release together cancel
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      outstanding <= '0;
    end else begin
      case ({alloc, release_credit})
        2'b10:   outstanding <= outstanding + 3'd1;
        2'b01:   outstanding <= outstanding - 3'd1;
        default: ; // hold
      endcase
    end
  end

endmodule

//--- src/command_control.sv
`timescale 1ns/1ps

module command_control
  import afu_cmd_pkg::*;
(
  input  logic             clock,
  input  logic             rstn,
  input  logic             line_valid,
  input  cmd_code_t        line_command,
  input  logic [63:0]      line_address,
  input  logic [11:0]      line_size,
  input  logic [TAG_W-1:0] line_tag,
  output logic             command_valid,
  output cmd_code_t        command_code,
  output logic [63:0]      command_address,
  output logic [11:0]      command_size,
  output logic [TAG_W-1:0] command_tag,
  output abort_t           command_abort,
  output logic [15:0]      command_context,
  output logic             command_tag_parity,
  output logic             command_code_parity,
  output logic             command_address_parity
);

  logic             latch_valid;
  cmd_code_t        latch_command;
  logic [63:0]      latch_address;
  logic [11:0]      latch_size;
  logic [TAG_W-1:0] latch_tag;

  //////////////////////////////////////////////////////////////////////
  // latch stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      latch_valid   <= 1'b0;
      latch_command <= CMD_INVALID;
      latch_address <= '0;
      latch_size    <= '0;
      latch_tag     <= INVALID_TAG;
    end else begin
      latch_valid   <= line_valid;
      latch_command <= line_command;
      latch_address <= line_address;
      latch_size    <= line_size;
      latch_tag     <= line_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stage, parity made from the latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_valid          <= 1'b0;
      command_code           <= CMD_INVALID;
      command_address        <= '0;
      command_size           <= '0;
      command_tag            <= INVALID_TAG;
      command_abort          <= ABORT;
      command_context        <= '0;
      command_tag_parity     <= 1'b0;
      command_code_parity    <= 1'b0;
      command_address_parity <= 1'b0;
    end else begin
      command_valid          <= latch_valid;
      command_code           <= latch_command;
      command_address        <= latch_address;
      command_size           <= latch_size;
      command_tag            <= latch_tag;
      command_abort          <= ABORT;   // fixed mode
      command_context        <= 16'h0;   // dedicated process, handle zero
      command_tag_parity     <= odd_parity(64'(latch_tag));
      command_code_parity    <= odd_parity(64'(latch_command));
      command_address_parity <= odd_parity(latch_address);
    end
  end

endmodule

//--- src/afu_cmd_top.sv
`timescale 1ns/1ps

module afu_cmd_top
  import afu_cmd_pkg::*;
(
  input  logic             clock,
  input  logic             rstn,
  // apb slave
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [7:0]       paddr,
  input  logic [31:0]      pwdata,
  output logic [31:0]      prdata,
  output logic             pslverr,
  // responses
  input  logic             response_valid,
  input  logic [TAG_W-1:0] response_tag,
  // command interface
  output logic             command_valid,
  output cmd_code_t        command_code,
  output logic [63:0]      command_address,
  output logic [11:0]      command_size,
  output logic [TAG_W-1:0] command_tag,
  output abort_t           command_abort,
  output logic [15:0]      command_context,
  output logic             command_tag_parity,
  output logic             command_code_parity,
  output logic             command_address_parity
);

  //////////////////////////////////////////////////////////////////////
  // internal nets
  //////////////////////////////////////////////////////////////////////

  logic             enabled;
  logic             req_pending;
  req_kind_t        req_kind;
  logic [63:0]      req_address;
  logic [11:0]      req_size;
  logic             req_taken;
  logic             alloc;
  logic             credit_free;
  logic [TAG_W-1:0] next_tag;
  logic [2:0]       outstanding;
  logic             line_valid;
  cmd_code_t        line_command;
  logic [63:0]      line_address;
  logic [11:0]      line_size;
  logic [TAG_W-1:0] line_tag;

  apb_cmd_regs u_regs (
    .clock, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata,
    .req_taken, .outstanding, .prdata, .pslverr, .enabled,
    .req_pending, .req_kind, .req_address, .req_size
  );

  cmd_request_fsm u_fsm (
    .clock, .rstn, .enabled, .req_pending, .req_kind, .req_address,
    .req_size, .credit_free, .next_tag, .req_taken, .alloc,
    .line_valid, .line_command, .line_address, .line_size, .line_tag
  );

  tag_credit_counter u_credits (
    .clock, .rstn, .alloc, .response_valid, .response_tag,
    .next_tag, .credit_free, .outstanding
  );

  command_control u_cmd_ctrl (
    .clock, .rstn, .line_valid, .line_command, .line_address,
    .line_size, .line_tag, .command_valid, .command_code,
    .command_address, .command_size, .command_tag, .command_abort,
    .command_context, .command_tag_parity, .command_code_parity,
    .command_address_parity
  );

endmodule

//--- sim/afu_cmd_sva.sv
`timescale 1ns/1ps

module afu_cmd_sva
  import afu_cmd_pkg::*;
(
  input logic             clock,
  input logic             rstn,
  input logic             line_valid,
  input logic             command_valid,
  input logic [TAG_W-1:0] command_tag,
  input logic             command_tag_parity
);

  //////////////////////////////////////////////////////////////////////
  // command port properties
  //////////////////////////////////////////////////////////////////////

  // output stage is cleared by rstn
  a_quiet_in_reset: assert property (@(posedge clock) !rstn |-> !command_valid)
    else $error("command_valid high while rstn is low");

  // latch then output, fixed two cycles
  a_fixed_latency: assert property (
    @(posedge clock) disable iff (!rstn) line_valid |-> ##2 command_valid
  ) else $error("line_valid not followed by command_valid two cycles later");

  a_tag_parity: assert property (
    @(posedge clock) disable iff (!rstn)
    command_valid |-> (command_tag_parity == odd_parity(64'(command_tag))) // odd over tag
  ) else $error("command_tag_parity wrong for tag %h", command_tag);

endmodule

//--- sim/tb_afu_cmd.sv
`timescale 1ns/1ps

module tb_afu_cmd
  import afu_cmd_pkg::*;
();

  localparam int NUM_REQ = 12;  // lines in the data file
  localparam int TIMEOUT = 200; // cycles per wait

  logic             clock;
  logic             rstn;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [7:0]       paddr;
  logic [31:0]      pwdata;
  logic [31:0]      prdata;
  logic             pslverr;
  logic             response_valid;
  logic [TAG_W-1:0] response_tag;
  logic             command_valid;
  cmd_code_t        command_code;
  logic [63:0]      command_address;
  logic [11:0]      command_size;
  logic [TAG_W-1:0] command_tag;
  abort_t           command_abort;
  logic [15:0]      command_context;
  logic             command_tag_parity;
  logic             command_code_parity;
  logic             command_address_parity;

  logic [63:0]      vectors [0:NUM_REQ*4-1]; // kind, address, size, code
  logic [TAG_W-1:0] exp_tag;
  logic [TAG_W-1:0] open_tags [$];            // issued, not yet answered
  int               mismatches;
  int               failures;
  int               observed;

  afu_cmd_top dut (.*);

  bind command_control afu_cmd_sva u_sva (
    .clock(clock), .rstn(rstn), .line_valid(line_valid), .command_valid(command_valid),
    .command_tag(command_tag), .command_tag_parity(command_tag_parity)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_code(input string name, input cmd_code_t exp, input cmd_code_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_W-1:0] exp,
                           input logic [TAG_W-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_abort(input string name, input abort_t exp, input abort_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus and response drivers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clock);
    #2; // inputs change just after the edge
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    psel    = 1'b1; // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1; // access phase, no wait states
    @(negedge clock);
    check_bit($sformatf("pslverr write %h", addr), exp_err, pslverr);
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    @(negedge clock); // mid access cycle, readback settled
    check_bit($sformatf("pslverr read %h", addr), exp_err, pslverr);
    data = prdata;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic respond(input logic [TAG_W-1:0] tag);
    response_valid = 1'b1; // one cycle pulse
    response_tag   = tag;
    next_cycle();
    response_valid = 1'b0;
  endtask

  task automatic respond_all();
    while (open_tags.size() > 0) respond(open_tags.pop_front());
  endtask

  // cycle 1 is the one after the REG_REQ access cycle
  task automatic wait_command(output int cycles);
    cycles = 1;
    while (command_valid !== 1'b1 && cycles < TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (command_valid !== 1'b1) begin
      failures++;
      $display("no command issued within timeout");
    end
  endtask

  // exp_latency 0 skips the latency check
  task automatic check_command(input string name, input logic [1:0] kind,
                               input logic [63:0] addr, input logic [11:0] size,
                               input cmd_code_t exp_code, input int exp_latency);
    int          cycles;
    logic [63:0] exp_addr;
    logic [11:0] exp_size;
    exp_addr = (kind == KIND_RESTART) ? 64'h0 : addr; // restart carries no target
    exp_size = (kind == KIND_RESTART) ? 12'h0 : size;
    wait_command(cycles);
    if (command_valid === 1'b1) begin
      if (exp_latency > 0) check_word({name, " latency"}, 64'(exp_latency), 64'(cycles));
      check_code({name, " code"}, exp_code, command_code);
      check_word({name, " address"}, exp_addr, command_address);
      check_word({name, " size"}, 64'(exp_size), 64'(command_size));
      check_tag({name, " tag"}, exp_tag, command_tag);
      check_abort({name, " abort"}, ABORT, command_abort);
      check_word({name, " context"}, 64'h0, 64'(command_context));
      check_bit({name, " tag parity"}, odd_parity(64'(exp_tag)), command_tag_parity);
      check_bit({name, " code parity"}, odd_parity(64'(exp_code)), command_code_parity);
      check_bit({name, " address parity"}, odd_parity(exp_addr), command_address_parity);
      open_tags.push_back(command_tag);
      observed++;
      exp_tag = TAG_W'((int'(exp_tag) + 1) % 255); // modulo 255, ff never handed out
      next_cycle();
      check_bit({name, " single cycle"}, 1'b0, command_valid);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    void'($urandom(45)); // one seed for the whole run
    rstn           = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    response_valid = 1'b0;
    response_tag   = '0;
    mismatches     = 0;
    failures       = 0;
    observed       = 0;
    exp_tag        = '0;
    $readmemh("sim/afu_cmd_testdata.txt", vectors);
    for (int i = 0; i < NUM_REQ; i++) begin
      if ($isunknown(vectors[4*i+3]) || vectors[4*i+3] == 64'h0) begin // a real code is never zero
        failures++;
        $display("test data line %0d is missing or holds no command code", i);
      end
    end
    repeat (4) @(posedge clock);
    #2;
    rstn = 1'b1;
    next_cycle();

    // quiet after reset
    apb_read(REG_STATUS, 1'b0, rdata);
    check_word("status after reset", 64'h0, 64'(rdata));
    check_tag("tag after reset", INVALID_TAG, command_tag);
    check_code("code after reset", CMD_INVALID, command_code);
    repeat (5) begin
      check_bit("valid while idle", 1'b0, command_valid);
      next_cycle();
    end
    apb_write(REG_CTRL, 32'h1, 1'b0);

    // one request per data line, each answered after a random delay
    for (int i = 0; i < NUM_REQ; i++) begin
      apb_write(REG_ADDR_LO, vectors[4*i+1][31:0], 1'b0);
      apb_write(REG_ADDR_HI, vectors[4*i+1][63:32], 1'b0);
      apb_write(REG_SIZE, vectors[4*i+2][31:0], 1'b0);
      apb_write(REG_REQ, 32'(vectors[4*i][1:0]), 1'b0);
      check_command($sformatf("request %0d", i), vectors[4*i][1:0], vectors[4*i+1],
                    vectors[4*i+2][11:0], cmd_code_t'(vectors[4*i+3][12:0]), 4);
      repeat ($urandom_range(5)) next_cycle();
      respond_all();
    end

    // fill every credit, then one more request must wait
    apb_write(REG_ADDR_LO, 32'h0000_4000, 1'b0);
    apb_write(REG_ADDR_HI, 32'h0, 1'b0);
    apb_write(REG_SIZE, 32'h080, 1'b0);
    repeat (MAX_CREDITS) begin
      apb_write(REG_REQ, 32'(KIND_WRITE), 1'b0);
      check_command("credit fill", KIND_WRITE, 64'h4000, 12'h080, CMD_WRITE_NA, 4);
    end
    apb_write(REG_REQ, 32'(KIND_WRITE), 1'b0);
    repeat (20) begin
      check_bit("valid without credit", 1'b0, command_valid);
      next_cycle();
    end
    respond(open_tags.pop_front()); // frees exactly one credit
    check_command("credit release", KIND_WRITE, 64'h4000, 12'h080, CMD_WRITE_NA, 0);
    apb_read(REG_STATUS, 1'b0, rdata);
    check_word("outstanding when full", 64'd4, 64'(rdata[10:8]));
    respond_all();
    next_cycle();
    apb_read(REG_STATUS, 1'b0, rdata);
    check_word("outstanding drained", 64'd0, 64'(rdata[10:8]));

    // bus errors and a request held by enable
    apb_write(REG_CTRL, 32'h0, 1'b0);
    apb_write(REG_REQ, 32'(KIND_READ), 1'b0);
    apb_write(REG_REQ, 32'(KIND_WRITE), 1'b1); // busy, dropped
    apb_write(8'h20, 32'h1, 1'b1);             // unmapped
    apb_read(8'h24, 1'b1, rdata);
    repeat (20) begin
      check_bit("valid while disabled", 1'b0, command_valid);
      next_cycle();
    end
    apb_read(REG_STATUS, 1'b0, rdata);
    check_bit("pending while held", 1'b1, rdata[0]);
    apb_write(REG_CTRL, 32'h1, 1'b0);
    check_command("released", KIND_READ, 64'h4000, 12'h080, CMD_READ_CL_NA, 0);
    respond_all();
    next_cycle();

    // issued count against what was seen on the command port
    apb_read(REG_STATUS, 1'b0, rdata);
    check_word("issued count", 64'(observed), 64'(rdata[31:16]));

    $display("commands %0d, mismatches %0d, other errors %0d", observed, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/afu_cmd_testdata.txt
// kind address size expected_code, all hex, one request per line
// restart lines still carry an address and size, the command must show zeros
0 0000000000001000 040 0001
1 0000000080000000 080 0a50
2 0000000012345680 080 0d00
3 00000000abcdef00 080 0a00
2 00007fff00000000 fff 0d00
3 ffffffffffffff80 001 0a00
1 0000000100000040 040 0a50
0 deadbeefcafef00d 123 0001
3 5555555555555555 aaa 0a00
2 aaaaaaaaaaaaaaaa 555 0d00
1 0123456789abcdef 800 0a50
3 0000000000000000 000 0a00

//--- tb.f
src/afu_cmd_pkg.sv
src/apb_cmd_regs.sv
src/cmd_request_fsm.sv
src/tag_credit_counter.sv
src/command_control.sv
src/afu_cmd_top.sv
sim/afu_cmd_sva.sv
sim/tb_afu_cmd.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_afu_cmd
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
